//--- Makefile
VERILATOR ?= verilator
TOP       := tb_datapath
FILELIST  := files.f
VFLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) verilog/tartaruga_cfg.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/tb_datapath.sv
`timescale 1ns/1ps
`include "tartaruga_cfg.svh"

module tb_datapath;
    import tartaruga_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int N_ALU = 22;
    localparam int N_DEP = 8;
    localparam int N_X0  = 7;
    localparam int N_CTL = 19;
    // Gap runs repeat the ALU and control programs
    localparam int TOTAL_COMMITS = 2 * N_ALU + N_DEP + N_X0 + 2 * N_CTL;

    typedef struct packed {
        bus32_t    pc;
        bus32_t    word;
        bus32_t    res;
        reg_addr_t rd;
        logic      we;
    } commit_t;

    logic      clk_i = 1'b0;
    logic      rstn_i;
    logic      imem_valid_i;
    bus32_t    imem_data_i;
    bus32_t    imem_addr_o;
    logic      imem_ready_o;
    logic      commit_valid_o;
    bus32_t    commit_pc_o;
    bus32_t    commit_instr_o;
    reg_addr_t commit_rd_o;
    logic      commit_we_o;
    bus32_t    commit_result_o;

    bus32_t  imem [64];
    commit_t exp_q [$];
    int      errors = 0;
    int      checks = 0;
    int      seed = 32'h10de;
    logic    gaps_on = 1'b0;
    logic    armed = 1'b0;

    datapath i_datapath (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .imem_addr_o     (imem_addr_o),
        .imem_ready_o    (imem_ready_o),
        .imem_valid_i    (imem_valid_i),
        .imem_data_i     (imem_data_i),
        .commit_valid_o  (commit_valid_o),
        .commit_pc_o     (commit_pc_o),
        .commit_instr_o  (commit_instr_o),
        .commit_rd_o     (commit_rd_o),
        .commit_we_o     (commit_we_o),
        .commit_result_o (commit_result_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    assign imem_data_i = imem[imem_addr_o[7:2]];

    always @(posedge clk_i) begin
        imem_valid_i <= !gaps_on || (($random(seed) & 3) != 0);
    end

    task automatic check_word(input string name, input bus32_t got, input bus32_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic bus32_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                      input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
    endfunction

    function automatic bus32_t i_type(input int imm, input int rs1, input logic [2:0] f3,
                                      input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic bus32_t b_type(input int off, input int rs2, input int rs1,
                                      input logic [2:0] f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic bus32_t u_type(input int imm, input int rd, input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic bus32_t j_type(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    // RV32I integer op as given by funct3 and the alternate bit
    function automatic bus32_t alu_ref(input logic [2:0] f3, input logic alt,
                                       input bus32_t a, input bus32_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input bus32_t a,
                                          input bus32_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Reference run over imem, fills the expected commit stream
    task automatic golden(input int n);
        bus32_t  x [32];
        bus32_t  pc;
        bus32_t  w;
        bus32_t  nxt;
        bus32_t  imm_i;
        bus32_t  imm_b;
        bus32_t  imm_j;
        commit_t e;
        pc = `TT_RESET_PC;
        for (int r = 0; r < 32; r++) begin
            x[r] = '0;
        end
        for (int k = 0; k < n; k++) begin
            w     = imem[pc[7:2]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            nxt   = pc + 32'd4;
            e.pc   = pc;
            e.word = w;
            e.rd   = w[11:7];
            e.we   = (w[11:7] != 5'd0);
            e.res  = '0;
            case (w[6:0])
                7'h37: e.res = {w[31:12], 12'h000};
                7'h17: e.res = pc + {w[31:12], 12'h000};
                7'h6f: begin
                    e.res = pc + 32'd4;
                    nxt   = pc + imm_j;
                end
                7'h67: begin
                    e.res = pc + 32'd4;
                    nxt   = (x[w[19:15]] + imm_i) & ~32'd1;
                end
                7'h63: begin
                    e.we = 1'b0;
                    if (branch_taken(w[14:12], x[w[19:15]], x[w[24:20]])) nxt = pc + imm_b;
                end
                7'h13: e.res = alu_ref(w[14:12], w[14:12] == 3'd5 && w[30], x[w[19:15]], imm_i);
                7'h33: e.res = alu_ref(w[14:12], w[30], x[w[19:15]], x[w[24:20]]);
                default: e.we = 1'b0;
            endcase
            if (e.we) x[e.rd] = e.res;
            exp_q.push_back(e);
            pc = nxt;
        end
    endtask

    always @(negedge clk_i) begin
        if (armed && commit_valid_o && exp_q.size() > 0) begin
            check_word("commit_pc_o", commit_pc_o, exp_q[0].pc);
            check_word("commit_instr_o", commit_instr_o, exp_q[0].word);
            check_bit("commit_we_o", commit_we_o, exp_q[0].we);
            if (exp_q[0].we) begin
                check_reg("commit_rd_o", commit_rd_o, exp_q[0].rd);
                check_word("commit_result_o", commit_result_o, exp_q[0].res);
            end
            void'(exp_q.pop_front());
        end
    end

    // Address dependent addi x0 so a stray commit shows its pc
    task automatic clear_imem();
        for (int i = 0; i < 64; i++) begin
            imem[i] = i_type(i * 4, 0, 3'd0, 0, 7'h13);
        end
    endtask

    task automatic run_prog(input string name, input int n, input logic gaps);
        int limit;
        limit = 16 * n + 10;
        armed = 1'b0;
        exp_q.delete();
        golden(n);
        gaps_on = gaps;
        @(posedge clk_i);
        rstn_i <= 1'b0;
        for (int c = 0; c < 3; c++) begin
            @(posedge clk_i);
            if (c == 2) rstn_i <= 1'b1;
            @(negedge clk_i);
            check_bit("commit_valid_o", commit_valid_o, 1'b0);
            check_word("imem_addr_o", imem_addr_o, `TT_RESET_PC);
            check_bit("imem_ready_o", imem_ready_o, 1'b1);
        end
        armed = 1'b1;
        // Three cycles from first transfer to commit
        if (!gaps) begin
            for (int k = 1; k <= 3; k++) begin
                @(negedge clk_i);
                check_bit("commit_valid_o", commit_valid_o, k == 3);
            end
        end
        for (int c = 0; c < limit && exp_q.size() > 0; c++) begin
            @(negedge clk_i);
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("%s: %0d of %0d expected commits never arrived", name, exp_q.size(), n);
        end
        armed = 1'b0;
    endtask

    task automatic test_alu(input logic gaps);
        clear_imem();
        imem[0]  = i_type(-5, 0, 3'd0, 1, 7'h13);
        imem[1]  = i_type(3, 0, 3'd0, 2, 7'h13);
        imem[2]  = u_type(20'h80000, 3, 7'h37);
        imem[3]  = u_type(20'h12345, 4, 7'h17);
        imem[4]  = i_type(0, 1, 3'd2, 5, 7'h13);
        imem[5]  = i_type(7, 1, 3'd3, 6, 7'h13);
        imem[6]  = i_type(12'h404, 3, 3'd5, 7, 7'h13);
        imem[7]  = i_type(4, 3, 3'd5, 8, 7'h13);
        imem[8]  = r_type(7'h00, 2, 1, 3'd2, 9);
        imem[9]  = r_type(7'h00, 2, 1, 3'd3, 10);
        imem[10] = r_type(7'h20, 1, 2, 3'd0, 11);
        imem[11] = r_type(7'h20, 2, 3, 3'd5, 12);
        imem[12] = i_type(12'h0f0, 2, 3'd4, 13, 7'h13);
        imem[13] = r_type(7'h00, 2, 1, 3'd6, 14);
        imem[14] = r_type(7'h00, 3, 1, 3'd7, 15);
        imem[15] = r_type(7'h00, 2, 2, 3'd1, 16);
        imem[16] = i_type(12'h07f, 1, 3'd7, 17, 7'h13);
        imem[17] = i_type(-256, 2, 3'd6, 18, 7'h13);
        imem[18] = r_type(7'h00, 3, 1, 3'd4, 19);
        imem[19] = r_type(7'h00, 2, 1, 3'd5, 20);
        imem[20] = i_type(31, 2, 3'd1, 21, 7'h13);
        imem[21] = r_type(7'h00, 3, 1, 3'd0, 22);
        run_prog("alu", N_ALU, gaps);
    endtask

    task automatic test_dependencies();
        clear_imem();
        imem[0] = i_type(1, 0, 3'd0, 1, 7'h13);
        imem[1] = i_type(2, 1, 3'd0, 2, 7'h13);
        imem[2] = r_type(7'h00, 2, 2, 3'd0, 3);
        imem[3] = i_type(7, 0, 3'd0, 4, 7'h13);
        imem[4] = i_type(1, 0, 3'd0, 9, 7'h13);
        imem[5] = r_type(7'h20, 3, 4, 3'd0, 5);
        imem[6] = i_type(3, 5, 3'd1, 6, 7'h13);
        imem[7] = r_type(7'h00, 6, 6, 3'd0, 7);
        run_prog("dependencies", N_DEP, 1'b0);
    endtask

    task automatic test_x0_writes();
        clear_imem();
        imem[0] = i_type(42, 0, 3'd0, 1, 7'h13);
        imem[1] = i_type(5, 1, 3'd0, 0, 7'h13);
        imem[2] = r_type(7'h00, 1, 1, 3'd0, 0);
        imem[3] = r_type(7'h00, 0, 0, 3'd0, 2);
        imem[4] = i_type(3, 0, 3'd0, 3, 7'h13);
        imem[5] = u_type(20'habcde, 0, 7'h37);
        imem[6] = r_type(7'h00, 1, 0, 3'd6, 4);
        run_prog("x0 writes", N_X0, 1'b0);
    endtask

    // Skipped slots keep their fill word and must never retire
    task automatic test_control_flow(input logic gaps);
        clear_imem();
        imem[0]  = i_type(5, 0, 3'd0, 1, 7'h13);
        imem[1]  = i_type(-3, 0, 3'd0, 2, 7'h13);
        imem[2]  = i_type(5, 0, 3'd0, 3, 7'h13);
        imem[3]  = b_type(12, 3, 1, 3'd0);
        imem[6]  = b_type(8, 3, 1, 3'd1);
        imem[7]  = b_type(12, 1, 2, 3'd4);
        imem[10] = b_type(8, 1, 2, 3'd6);
        imem[11] = b_type(12, 2, 1, 3'd5);
        imem[14] = b_type(12, 1, 2, 3'd7);
        imem[17] = j_type(12, 5);
        imem[20] = i_type(16, 5, 3'd0, 6, 7'h67);
        imem[22] = b_type(8, 2, 1, 3'd0);
        imem[23] = b_type(8, 2, 1, 3'd4);
        imem[24] = i_type(1, 6, 3'd0, 7, 7'h13);
        imem[25] = b_type(12, 2, 1, 3'd1);
        imem[28] = b_type(12, 2, 1, 3'd6);
        imem[31] = b_type(8, 1, 2, 3'd5);
        imem[32] = b_type(8, 2, 1, 3'd7);
        imem[33] = i_type(9, 0, 3'd0, 8, 7'h13);
        run_prog("control flow", N_CTL, gaps);
    endtask

    initial begin
        rstn_i       = 1'b0;
        imem_valid_i = 1'b0;
        clear_imem();
        test_alu(1'b0);
        test_dependencies();
        test_x0_writes();
        test_control_flow(1'b0);
        test_alu(1'b1);
        test_control_flow(1'b1);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((20 * TOTAL_COMMITS + 200) * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", 20 * TOTAL_COMMITS + 200);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- files.f
+incdir+verilog
verilog/tartaruga_pkg.sv
verilog/exe_bus_if.sv
verilog/fetch.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/datapath.sv
bench/tb_datapath.sv

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    exe_bus_if.unit               bus,
    output tartaruga_pkg::bus32_t alu_result_o
);
    import tartaruga_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = bus.op_b[4:0];
    assign lt_signed   = $signed(bus.op_a) < $signed(bus.op_b);
    assign lt_unsigned = bus.op_a < bus.op_b;

    always_comb begin
        alu_result_o = '0;
        case (bus.alu_op)
            ADD:  alu_result_o = bus.op_a + bus.op_b;
            SUB:  alu_result_o = bus.op_a - bus.op_b;
            SLL:  alu_result_o = bus.op_a << shamt;
            SLT:  alu_result_o[0] = lt_signed;
            SLTU: alu_result_o[0] = lt_unsigned;
            XOR:  alu_result_o = bus.op_a ^ bus.op_b;
            SRL:  alu_result_o = bus.op_a >> shamt;
            // Sign bit fills from the left
            SRA:  alu_result_o = $signed(bus.op_a) >>> shamt;
            OR:   alu_result_o = bus.op_a | bus.op_b;
            AND:  alu_result_o = bus.op_a & bus.op_b;
            PASS_B: begin
                alu_result_o = bus.op_b;
            end
            default: begin
                alu_result_o = '0;
            end
        endcase
    end

endmodule

//--- verilog/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    exe_bus_if.unit               bus,
    output logic                  taken_o,
    output tartaruga_pkg::bus32_t target_o,
    output tartaruga_pkg::bus32_t link_o
);
    import tartaruga_pkg::*;

    logic   cond;
    bus32_t jalr_sum;

    // Operand a carries rs1 for every control transfer
    always_comb begin
        case (bus.jump_kind)
            BEQ:       cond = (bus.op_a == bus.rs2_data);
            BNE:       cond = (bus.op_a != bus.rs2_data);
            BLT:       cond = ($signed(bus.op_a) < $signed(bus.rs2_data));
            BGE:       cond = ($signed(bus.op_a) >= $signed(bus.rs2_data));
            BLTU:      cond = (bus.op_a < bus.rs2_data);
            BGEU:      cond = (bus.op_a >= bus.rs2_data);
            JAL, JALR: cond = 1'b1;
            default:   cond = 1'b0;
        endcase
    end

    assign taken_o = bus.valid && cond;

    assign jalr_sum = bus.op_a + bus.imm;
    assign target_o = (bus.jump_kind == JALR) ? {jalr_sum[31:1], 1'b0} : bus.pc + bus.imm;

    assign link_o = bus.pc + 32'd4;

endmodule

//--- verilog/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    output tartaruga_pkg::bus32_t    imem_addr_o,
    output logic                     imem_ready_o,
    input  logic                     imem_valid_i,
    input  tartaruga_pkg::bus32_t    imem_data_i,
    output logic                     commit_valid_o,
    output tartaruga_pkg::bus32_t    commit_pc_o,
    output tartaruga_pkg::bus32_t    commit_instr_o,
    output tartaruga_pkg::reg_addr_t commit_rd_o,
    output logic                     commit_we_o,
    output tartaruga_pkg::bus32_t    commit_result_o
);
    import tartaruga_pkg::*;

    function automatic logic raw_hazard(input reg_addr_t rs, input instr_t older);
        return older.write_enable && (older.addr_rd != '0) && (older.addr_rd == rs);
    endfunction

    logic       stall;
    logic       redirect;
    bus32_t     redirect_pc;
    logic       fetch_valid;
    bus32_t     fetch_pc;
    logic       if_id_valid_q;
    bus32_t     if_id_word_q;
    bus32_t     if_id_pc_q;
    instr_t     dec_instr;
    bus32_t     rs1_data, rs2_data;
    instr_t     id_ex_q;
    bus32_t     id_ex_rs1_q, id_ex_rs2_q;
    bus32_t     alu_result;
    bus32_t     link;
    bus32_t     exe_result;
    exe_to_wb_t wb_q;

    fetch i_fetch (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_valid_i  (imem_valid_i),
        .imem_ready_o  (imem_ready_o),
        .imem_addr_o   (imem_addr_o),
        .fetch_valid_o (fetch_valid),
        .fetch_pc_o    (fetch_pc)
    );

    // Fetch/decode register, held on stall
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            if_id_valid_q <= 1'b0;
        end else if (redirect) begin
            if_id_valid_q <= 1'b0;
        end else if (!stall) begin
            if_id_valid_q <= fetch_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            if_id_word_q <= imem_data_i;
            if_id_pc_q   <= fetch_pc;
        end
    end

    decoder i_decoder (
        .valid_i         (if_id_valid_q),
        .pc_i            (if_id_pc_q),
        .instr_word_i    (if_id_word_q),
        .instr_decoded_o (dec_instr)
    );

    regfile i_regfile (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .addr_rs1_i     (dec_instr.addr_rs1),
        .addr_rs2_i     (dec_instr.addr_rs2),
        .addr_rd_i      (wb_q.instr.addr_rd),
        .data_rd_i      (wb_q.result),
        .write_enable_i (wb_q.instr.write_enable),
        .data_rs1_o     (rs1_data),
        .data_rs2_o     (rs2_data)
    );

    // No forwarding, so wait until the producer has left writeback
    assign stall = raw_hazard(dec_instr.addr_rs1, id_ex_q)
                || raw_hazard(dec_instr.addr_rs2, id_ex_q)
                || raw_hazard(dec_instr.addr_rs1, wb_q.instr)
                || raw_hazard(dec_instr.addr_rs2, wb_q.instr);

    always_ff @(posedge clk_i) begin
        if (!rstn_i || redirect || stall) begin
            id_ex_q <= NOP_INSTR;
        end else begin
            id_ex_q <= dec_instr;
        end
    end

    always_ff @(posedge clk_i) begin
        id_ex_rs1_q <= rs1_data;
        id_ex_rs2_q <= rs2_data;
    end

    exe_bus_if i_exe_bus ();

    assign i_exe_bus.pc        = id_ex_q.pc;
    assign i_exe_bus.op_a      = (id_ex_q.opa_sel == PC) ? id_ex_q.pc : id_ex_rs1_q;
    assign i_exe_bus.op_b      = (id_ex_q.opb_sel == IMM) ? id_ex_q.imm : id_ex_rs2_q;
    assign i_exe_bus.rs2_data  = id_ex_rs2_q;
    assign i_exe_bus.imm       = id_ex_q.imm;
    assign i_exe_bus.alu_op    = id_ex_q.alu_op;
    assign i_exe_bus.jump_kind = id_ex_q.jump_kind;
    assign i_exe_bus.valid     = id_ex_q.valid;

    alu i_alu (
        .bus          (i_exe_bus),
        .alu_result_o (alu_result)
    );

    branch_unit i_branch_unit (
        .bus      (i_exe_bus),
        .taken_o  (redirect),
        .target_o (redirect_pc),
        .link_o   (link)
    );

    // Jumps write the return address, branches carry write_enable low
    assign exe_result = (id_ex_q.jump_kind == JAL || id_ex_q.jump_kind == JALR)
                      ? link : alu_result;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wb_q <= '0;
        end else begin
            wb_q.instr  <= id_ex_q;
            wb_q.result <= exe_result;
        end
    end

    assign commit_valid_o  = wb_q.instr.valid;
    assign commit_pc_o     = wb_q.instr.pc;
    assign commit_instr_o  = wb_q.instr.word;
    assign commit_rd_o     = wb_q.instr.addr_rd;
    assign commit_we_o     = wb_q.instr.write_enable;
    assign commit_result_o = wb_q.result;

endmodule

//--- verilog/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic                  valid_i,
    input  tartaruga_pkg::bus32_t pc_i,
    input  tartaruga_pkg::bus32_t instr_word_i,
    output tartaruga_pkg::instr_t instr_decoded_o
);
    import tartaruga_pkg::*;

    function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1, rs2, rd;
    bus32_t     imm_i, imm_b, imm_u, imm_j;
    instr_t     dec;
    logic       ok;

    assign opcode = opcode_t'(instr_word_i[6:0]);
    assign funct3 = instr_word_i[14:12];
    assign funct7 = instr_word_i[31:25];
    assign rd     = instr_word_i[11:7];
    assign rs1    = instr_word_i[19:15];
    assign rs2    = instr_word_i[24:20];

    assign imm_i = {{20{instr_word_i[31]}}, instr_word_i[31:20]};
    assign imm_b = {{19{instr_word_i[31]}}, instr_word_i[31], instr_word_i[7],
                    instr_word_i[30:25], instr_word_i[11:8], 1'b0};
    assign imm_u = {instr_word_i[31:12], 12'b0};
    assign imm_j = {{11{instr_word_i[31]}}, instr_word_i[31], instr_word_i[19:12],
                    instr_word_i[20], instr_word_i[30:21], 1'b0};

    always_comb begin
        dec = NOP_INSTR;
        ok  = 1'b1;
        case (opcode)
            OP_LUI: begin
                dec.addr_rd = rd;
                dec.opb_sel = IMM;
                dec.alu_op  = PASS_B;
                dec.imm     = imm_u;
            end
            OP_AUIPC: begin
                dec.addr_rd = rd;
                dec.opa_sel = PC;
                dec.opb_sel = IMM;
                dec.imm     = imm_u;
            end
            OP_JAL: begin
                dec.addr_rd   = rd;
                dec.jump_kind = JAL;
                dec.imm       = imm_j;
            end
            OP_JALR: begin
                dec.addr_rs1  = rs1;
                dec.addr_rd   = rd;
                dec.jump_kind = JALR;
                dec.imm       = imm_i;
                ok = (funct3 == 3'b000);
            end
            OP_BRANCH: begin
                dec.addr_rs1 = rs1;
                dec.addr_rs2 = rs2;
                dec.imm      = imm_b;
                case (funct3)
                    3'b000:  dec.jump_kind = BEQ;
                    3'b001:  dec.jump_kind = BNE;
                    3'b100:  dec.jump_kind = BLT;
                    3'b101:  dec.jump_kind = BGE;
                    3'b110:  dec.jump_kind = BLTU;
                    3'b111:  dec.jump_kind = BGEU;
                    default: ok = 1'b0;
                endcase
            end
            OP_IMM: begin
                dec.addr_rs1 = rs1;
                dec.addr_rd  = rd;
                dec.opb_sel  = IMM;
                dec.imm      = imm_i;
                dec.alu_op   = funct_to_alu(funct3, (funct3 == 3'b101) && funct7[5]);
                ok = !((funct3 == 3'b001 && funct7 != 7'b0)
                    || (funct3 == 3'b101 && funct7 != 7'b0 && funct7 != 7'b0100000));
            end
            OP_REG: begin
                dec.addr_rs1 = rs1;
                dec.addr_rs2 = rs2;
                dec.addr_rd  = rd;
                dec.alu_op   = funct_to_alu(funct3, funct7[5]);
                ok = (funct7 == 7'b0)
                    || (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            default: ok = 1'b0;
        endcase

        // Unknown encodings still retire, doing nothing
        if (!ok) begin
            dec = NOP_INSTR;
        end
        dec.write_enable = (dec.addr_rd != '0);
        dec.pc    = pc_i;
        dec.word  = instr_word_i;
        dec.valid = 1'b1;

        instr_decoded_o = valid_i ? dec : NOP_INSTR;
    end

endmodule

//--- verilog/exe_bus_if.sv
`timescale 1ns/1ps

interface exe_bus_if;
    import tartaruga_pkg::*;

    bus32_t     pc;
    bus32_t     op_a;
    bus32_t     op_b;
    bus32_t     rs2_data;
    bus32_t     imm;
    alu_op_t    alu_op;
    jump_kind_t jump_kind;
    logic       valid;

    // Driven from the decode/execute register
    modport stage (
        output pc, op_a, op_b, rs2_data, imm, alu_op, jump_kind, valid
    );

    // Execute units only look
    modport unit (
        input pc, op_a, op_b, rs2_data, imm, alu_op, jump_kind, valid
    );

endinterface

//--- verilog/fetch.sv
`timescale 1ns/1ps
`include "tartaruga_cfg.svh"

module fetch (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  stall_i,
    input  logic                  redirect_i,
    input  tartaruga_pkg::bus32_t redirect_pc_i,
    input  logic                  imem_valid_i,
    output logic                  imem_ready_o,
    output tartaruga_pkg::bus32_t imem_addr_o,
    output logic                  fetch_valid_o,
    output tartaruga_pkg::bus32_t fetch_pc_o
);
    import tartaruga_pkg::*;

    bus32_t pc_q;
    logic   transfer;

    assign imem_ready_o = !stall_i;
    assign transfer     = imem_valid_i && imem_ready_o;
    assign imem_addr_o  = pc_q;
    assign fetch_pc_o   = pc_q;

    // Wrong-path words are dropped by the flush in the fetch/decode register
    assign fetch_valid_o = transfer;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pc_q <= `TT_RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (transfer) begin
            pc_q <= pc_q + 32'd4;
        end
    end

endmodule

//--- verilog/regfile.sv
`timescale 1ns/1ps
`include "tartaruga_cfg.svh"

module regfile (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  tartaruga_pkg::reg_addr_t addr_rs1_i,
    input  tartaruga_pkg::reg_addr_t addr_rs2_i,
    input  tartaruga_pkg::reg_addr_t addr_rd_i,
    input  tartaruga_pkg::bus32_t    data_rd_i,
    input  logic                     write_enable_i,
    output tartaruga_pkg::bus32_t    data_rs1_o,
    output tartaruga_pkg::bus32_t    data_rs2_o
);
    import tartaruga_pkg::*;

    // No storage behind x0
    bus32_t regs_q [1:`TT_NUM_REGS-1];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 1; i < `TT_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (write_enable_i && (addr_rd_i != '0)) begin
            regs_q[addr_rd_i] <= data_rd_i;
        end
    end

    assign data_rs1_o = (addr_rs1_i == '0) ? '0 : regs_q[addr_rs1_i];
    assign data_rs2_o = (addr_rs2_i == '0) ? '0 : regs_q[addr_rs2_i];

endmodule

//--- verilog/tartaruga_cfg.svh
`ifndef TARTARUGA_CFG_SVH
`define TARTARUGA_CFG_SVH

// First fetch address after reset
`define TT_RESET_PC 32'h0000_0000

// Integer register width
`define TT_XLEN 32

// Architectural registers, x0 included
`define TT_NUM_REGS 32

`endif

//--- verilog/tartaruga_pkg.sv
`include "tartaruga_cfg.svh"

package tartaruga_pkg;

    typedef logic [`TT_XLEN-1:0] bus32_t;
    typedef logic [$clog2(`TT_NUM_REGS)-1:0] reg_addr_t;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } alu_op_t;

    typedef enum logic [3:0] {
        BNONE, BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR
    } jump_kind_t;

    typedef enum logic {RS1, PC} opa_sel_t;
    typedef enum logic {RS2, IMM} opb_sel_t;

    typedef struct packed {
        bus32_t     pc;
        bus32_t     word;
        reg_addr_t  addr_rs1;
        reg_addr_t  addr_rs2;
        reg_addr_t  addr_rd;
        logic       write_enable;
        opa_sel_t   opa_sel;
        opb_sel_t   opb_sel;
        alu_op_t    alu_op;
        jump_kind_t jump_kind;
        bus32_t     imm;
        logic       valid;
    } instr_t;

    typedef struct packed {
        instr_t instr;
        bus32_t result;
    } exe_to_wb_t;

    // Bubble: every enum field decodes to its zero member
    localparam instr_t NOP_INSTR = '0;

endpackage
